// File: source/emu_link_pkg.sv
package emu_link_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Link constants
    ////////////////////////////////////////////////////////////////////////////

    // Generator and checker shift register length
    localparam int PRBS_WIDTH = 32;
    // Low and high time configuration in time steps
    localparam int TIME_W     = 8;
    localparam int SAMPLE_W   = 16;
    // Drive level magnitude in sample units
    localparam int TX_AMP     = 8192;
    // Quarter of the remaining gap per step
    localparam int CHAN_SHIFT = 2;
    localparam int LOCK_BITS  = 32;
    localparam int CNT_W      = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // One fixed-point analog sample
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] value;
    } analog_t;

    // Receiver status as seen at the top level
    typedef struct packed {
        logic             locked;
        logic [CNT_W-1:0] bit_count;
        logic [CNT_W-1:0] err_count;
    } link_status_t;

    typedef enum logic {
        OSC_LOW,
        OSC_HIGH
    } osc_state_e;

    typedef enum logic {
        CHK_HUNT,
        CHK_LOCKED
    } chk_state_e;

endpackage

// File: source/osc_model_core.sv
`timescale 1ns/1ns

module osc_model_core (
    input  logic                              emu_clk,
    input  logic                              emu_rst,
    input  logic [emu_link_pkg::TIME_W-1:0]   t_lo_i,
    input  logic [emu_link_pkg::TIME_W-1:0]   t_hi_i,
    output logic                              clk_val_o,
    output logic                              bit_stb_o
);

    import emu_link_pkg::*;

    osc_state_e        state;
    logic [TIME_W-1:0] step_cnt;
    // Length of the current phase, latched at each phase change
    logic [TIME_W-1:0] phase_len;
    logic [TIME_W:0]   step_inc;
    logic              phase_done;
    logic              clk_val_q;

    ////////////////////////////////////////////////////////////////////////////
    // Phase counter
    ////////////////////////////////////////////////////////////////////////////

    // A zero length behaves like a length of one
    assign step_inc   = {1'b0, step_cnt} + 1'b1;
    assign phase_done = step_inc >= {1'b0, phase_len};

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            state     <= OSC_LOW;
            step_cnt  <= '0;
            phase_len <= t_lo_i;
        end else if (phase_done) begin
            step_cnt <= '0;
            if (state == OSC_LOW) begin
                state     <= OSC_HIGH;
                phase_len <= t_hi_i;
            end else begin
                state     <= OSC_LOW;
                phase_len <= t_lo_i;
            end
        end else begin
            step_cnt <= step_inc[TIME_W-1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Rising edge strobe
    ////////////////////////////////////////////////////////////////////////////

    assign clk_val_o = (state == OSC_HIGH);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            clk_val_q <= 1'b0;
        end else begin
            clk_val_q <= clk_val_o;
        end
    end

    // High only in the first cycle of each high phase
    assign bit_stb_o = clk_val_o & ~clk_val_q;

endmodule

// File: source/prbs_generator_syn.sv
`timescale 1ns/1ns

module prbs_generator_syn (
    input  logic                                emu_clk,
    input  logic                                emu_rst,
    input  logic                                cke_i,
    input  logic [emu_link_pkg::PRBS_WIDTH-1:0] init_val_i,
    input  logic [emu_link_pkg::PRBS_WIDTH-1:0] eqn_i,
    input  logic                                inj_err_i,
    output logic                                out_o
);

    import emu_link_pkg::*;

    // Bit 0 holds the newest feedback bit
    logic [PRBS_WIDTH-1:0] lfsr_q;
    logic                  fb_bit;
    logic                  out_q;

    ////////////////////////////////////////////////////////////////////////////
    // Fibonacci shift register
    ////////////////////////////////////////////////////////////////////////////

    // Parity of the tapped state bits
    assign fb_bit = ^(lfsr_q & eqn_i);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            lfsr_q <= init_val_i;
        end else if (cke_i) begin
            lfsr_q <= {lfsr_q[PRBS_WIDTH-2:0], fb_bit};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output bit
    ////////////////////////////////////////////////////////////////////////////

    // Injected error flips the line bit only
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            out_q <= 1'b0;
        end else if (cke_i) begin
            out_q <= fb_bit ^ inj_err_i;
        end
    end

    assign out_o = out_q;

endmodule

// File: source/tx_core.sv
`timescale 1ns/1ns

module tx_core (
    input  logic                  emu_clk,
    input  logic                  emu_rst,
    input  logic                  in_i,
    input  logic                  cke_i,
    output emu_link_pkg::analog_t out_o
);

    import emu_link_pkg::*;

    localparam logic signed [SAMPLE_W-1:0] LEVEL_HI = SAMPLE_W'(TX_AMP);
    localparam logic signed [SAMPLE_W-1:0] LEVEL_LO = SAMPLE_W'(-TX_AMP);

    // Generator bit settles one cycle after the strobe
    logic    cke_q;
    analog_t level_q;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            cke_q <= 1'b0;
        end else begin
            cke_q <= cke_i;
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            level_q.value <= LEVEL_LO;
        end else if (cke_q) begin
            level_q.value <= in_i ? LEVEL_HI : LEVEL_LO;
        end
    end

    assign out_o = level_q;

endmodule

// File: source/chan_core.sv
`timescale 1ns/1ns

module chan_core (
    input  logic                  emu_clk,
    input  logic                  emu_rst,
    input  emu_link_pkg::analog_t in_i,
    output emu_link_pkg::analog_t out_o
);

    import emu_link_pkg::*;

    localparam logic signed [SAMPLE_W+1:0] SAT_MAX = (SAMPLE_W + 2)'(2 ** (SAMPLE_W - 1) - 1);
    localparam logic signed [SAMPLE_W+1:0] SAT_MIN = (SAMPLE_W + 2)'(-(2 ** (SAMPLE_W - 1)));

    analog_t                    state_q;
    logic signed [SAMPLE_W:0]   diff;
    logic signed [SAMPLE_W:0]   step;
    logic signed [SAMPLE_W+1:0] sum_w;
    logic signed [SAMPLE_W-1:0] next_val;

    ////////////////////////////////////////////////////////////////////////////
    // Low-pass update
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        diff  = {in_i.value[SAMPLE_W-1], in_i.value} - {state_q.value[SAMPLE_W-1], state_q.value};
        // Fraction of the gap closed per time step
        step  = diff >>> CHAN_SHIFT;
        sum_w = {step[SAMPLE_W], step} + {{2{state_q.value[SAMPLE_W-1]}}, state_q.value};
        if (sum_w > SAT_MAX) begin
            next_val = SAT_MAX[SAMPLE_W-1:0];
        end else if (sum_w < SAT_MIN) begin
            next_val = SAT_MIN[SAMPLE_W-1:0];
        end else begin
            next_val = sum_w[SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            state_q.value <= '0;
        end else begin
            state_q.value <= next_val;
        end
    end

    assign out_o = state_q;

endmodule

// File: source/rx_core.sv
`timescale 1ns/1ns

module rx_core (
    input  logic                                emu_clk,
    input  logic                                emu_rst,
    input  emu_link_pkg::analog_t               in_i,
    input  logic                                cke_i,
    input  logic [emu_link_pkg::PRBS_WIDTH-1:0] eqn_i,
    output emu_link_pkg::link_status_t          status_o
);

    import emu_link_pkg::*;

    localparam int GOOD_W = $clog2(LOCK_BITS + 1);

    chk_state_e            state;
    // Received bits, newest in bit 0
    logic [PRBS_WIDTH-1:0] hist_q;
    logic [GOOD_W-1:0]     good_cnt;
    logic [CNT_W-1:0]      bit_cnt;
    logic [CNT_W-1:0]      err_cnt;
    logic                  rx_bit;
    logic                  pred_bit;
    logic                  mismatch;

    ////////////////////////////////////////////////////////////////////////////
    // Slicer and prediction
    ////////////////////////////////////////////////////////////////////////////

    // Decision threshold at zero
    assign rx_bit   = ~in_i.value[SAMPLE_W-1];
    assign pred_bit = ^(hist_q & eqn_i);
    assign mismatch = rx_bit ^ pred_bit;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            hist_q <= '0;
        end else if (cke_i) begin
            hist_q <= {hist_q[PRBS_WIDTH-2:0], rx_bit};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Lock FSM and counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            state    <= CHK_HUNT;
            good_cnt <= '0;
            bit_cnt  <= '0;
            err_cnt  <= '0;
        end else if (cke_i) begin
            case (state)
                CHK_HUNT: begin
                    if (mismatch) begin
                        good_cnt <= '0;
                    end else if (good_cnt == GOOD_W'(LOCK_BITS - 1)) begin
                        state <= CHK_LOCKED;
                    end else begin
                        good_cnt <= good_cnt + 1'b1;
                    end
                end
                CHK_LOCKED: begin
                    // Lock holds until reset
                    if (bit_cnt != '1) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    if (mismatch && (err_cnt != '1)) begin
                        err_cnt <= err_cnt + 1'b1;
                    end
                end
                default: state <= CHK_HUNT;
            endcase
        end
    end

    assign status_o.locked    = (state == CHK_LOCKED);
    assign status_o.bit_count = bit_cnt;
    assign status_o.err_count = err_cnt;

endmodule

// File: source/emu_link_top.sv
`timescale 1ns/1ns

module emu_link_top (
    input  logic                                emu_clk,
    input  logic                                emu_rst,
    input  logic [emu_link_pkg::TIME_W-1:0]     t_lo_i,
    input  logic [emu_link_pkg::TIME_W-1:0]     t_hi_i,
    input  logic [emu_link_pkg::PRBS_WIDTH-1:0] seed_i,
    input  logic [emu_link_pkg::PRBS_WIDTH-1:0] eqn_i,
    input  logic                                inj_err_i,
    output logic                                bit_stb_o,
    output emu_link_pkg::link_status_t          status_o
);

    import emu_link_pkg::*;

    logic    bit_stb;
    logic    tx_bit;
    analog_t tx_level;
    analog_t rx_level;

    ////////////////////////////////////////////////////////////////////////////
    // Bit clock and data source
    ////////////////////////////////////////////////////////////////////////////

    osc_model_core u_osc (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .t_lo_i    (t_lo_i),
        .t_hi_i    (t_hi_i),
        .clk_val_o (),
        .bit_stb_o (bit_stb)
    );

    prbs_generator_syn u_prbs_gen (
        .emu_clk    (emu_clk),
        .emu_rst    (emu_rst),
        .cke_i      (bit_stb),
        .init_val_i (seed_i),
        .eqn_i      (eqn_i),
        .inj_err_i  (inj_err_i),
        .out_o      (tx_bit)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Line path
    ////////////////////////////////////////////////////////////////////////////

    tx_core u_tx (
        .emu_clk (emu_clk),
        .emu_rst (emu_rst),
        .in_i    (tx_bit),
        .cke_i   (bit_stb),
        .out_o   (tx_level)
    );

    chan_core u_chan (
        .emu_clk (emu_clk),
        .emu_rst (emu_rst),
        .in_i    (tx_level),
        .out_o   (rx_level)
    );

    // Receiver decides on the strobe itself
    rx_core u_rx (
        .emu_clk  (emu_clk),
        .emu_rst  (emu_rst),
        .in_i     (rx_level),
        .cke_i    (bit_stb),
        .eqn_i    (eqn_i),
        .status_o (status_o)
    );

    assign bit_stb_o = bit_stb;

endmodule

// File: dv/emu_link_chk.sv
`timescale 1ns/1ns

module emu_link_chk (
    input logic                       emu_clk,
    input logic                       emu_rst,
    input logic                       bit_stb_i,
    input emu_link_pkg::link_status_t status_i
);

    ////////////////////////////////////////////////////////////////////////////
    // Bit strobe
    ////////////////////////////////////////////////////////////////////////////

    // One-cycle pulse per bit period
    a_stb_single: assert property (@(posedge emu_clk) disable iff (emu_rst)
        bit_stb_i |=> !bit_stb_i)
        else $error("bit strobe held high for two cycles");

    ////////////////////////////////////////////////////////////////////////////
    // Receiver status
    ////////////////////////////////////////////////////////////////////////////

    a_err_monotonic: assert property (@(posedge emu_clk) disable iff (emu_rst)
        status_i.err_count >= $past(status_i.err_count))
        else $error("error counter decreased");

    // Lock is only cleared by reset
    a_lock_held: assert property (@(posedge emu_clk) disable iff (emu_rst)
        !$fell(status_i.locked))
        else $error("receiver lost lock outside reset");

endmodule

// File: dv/tb.sv
`timescale 1ns/1ns

module tb;

    import emu_link_pkg::*;

    // PRBS32 is x^32 + x^22 + x^2 + x + 1, PRBS7 is x^7 + x^6 + 1
    localparam logic [PRBS_WIDTH-1:0] PRBS32_EQN  = 32'h8020_0003;
    localparam logic [PRBS_WIDTH-1:0] PRBS7_EQN   = 32'h0000_0060;
    localparam logic [PRBS_WIDTH-1:0] SEED32      = 32'hC0DE_5A17;
    localparam logic [PRBS_WIDTH-1:0] SEED7       = 32'h0000_004D;
    localparam logic [15:0]           LFSR_SEED   = 16'd27265;
    localparam int                    STB_TIMEOUT = 1024;

    logic                  emu_clk;
    logic                  emu_rst;
    logic [TIME_W-1:0]     t_lo;
    logic [TIME_W-1:0]     t_hi;
    logic [PRBS_WIDTH-1:0] seed;
    logic [PRBS_WIDTH-1:0] eqn;
    logic                  inj_err;
    logic                  bit_stb;
    link_status_t          status;
    logic [15:0]           lfsr_q;
    // Errors the link should have counted since the last reset
    logic [CNT_W-1:0]      err_exp;
    int                    err_total;
    logic                  run_done;

    emu_link_top u_dut (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .t_lo_i    (t_lo),
        .t_hi_i    (t_hi),
        .seed_i    (seed),
        .eqn_i     (eqn),
        .inj_err_i (inj_err),
        .bit_stb_o (bit_stb),
        .status_o  (status)
    );

    bind emu_link_top emu_link_chk u_chk (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .bit_stb_i (bit_stb_o),
        .status_i  (status_o)
    );

    initial begin
        emu_clk = 1'b0;
        forever #5 emu_clk = ~emu_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting and compares
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_error(input string msg);
        err_total++;
        $display("error at %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_stall(input string msg);
        err_total++;
        $display("The simulation stalled: %s", msg);
        $display("Finished with errors");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic compare_status(input link_status_t got, input link_status_t exp,
                                  input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %0b/%0d/%0d, expected %0b/%0d/%0d", what,
                got.locked, got.bit_count, got.err_count,
                exp.locked, exp.bit_count, exp.err_count));
        end
    endtask

    task automatic compare_count(input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] exp,
                                 input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val    = (val << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // Config is loaded while reset is high
    task automatic start_link(input logic [TIME_W-1:0] lo, input logic [TIME_W-1:0] hi,
                              input logic [PRBS_WIDTH-1:0] sd,
                              input logic [PRBS_WIDTH-1:0] eq);
        t_lo    = lo;
        t_hi    = hi;
        seed    = sd;
        eqn     = eq;
        inj_err = 1'b0;
        err_exp = '0;
        emu_rst = 1'b1;
        repeat (2) @(posedge emu_clk);
        #1;
        emu_rst = 1'b0;
    endtask

    task automatic wait_strobe(output int cycles);
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge emu_clk);
            #1;
            cycles++;
            seen = bit_stb;
            if (!seen && cycles >= STB_TIMEOUT) begin
                report_stall($sformatf("no bit strobe within %0d cycles", STB_TIMEOUT));
            end
        end
    endtask

    // Returns one cycle after the last strobe so the counters have settled
    task automatic run_bits(input int n);
        int cycles;
        repeat (n) wait_strobe(cycles);
        @(posedge emu_clk);
        #1;
    endtask

    task automatic wait_lock(input int max_bits);
        int n;
        n = 0;
        while (!status.locked) begin
            if (n >= max_bits) begin
                report_stall($sformatf("link did not lock within %0d bits", max_bits));
            end
            run_bits(1);
            n++;
        end
    endtask

    // Generator samples the flag at the end of the strobe cycle
    task automatic inject_error();
        int cycles;
        wait_strobe(cycles);
        inj_err = 1'b1;
        @(posedge emu_clk);
        #1;
        inj_err = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        link_status_t zero_st;
        zero_st = '0;
        @(posedge emu_clk);
        #1;
        compare_status(status, zero_st, "status during reset");
        @(posedge emu_clk);
        #1;
        emu_rst = 1'b0;
        @(posedge emu_clk);
        #1;
        compare_status(status, zero_st, "status after reset");
    endtask

    task automatic test_strobe_period();
        int lo_tab [3] = '{5, 12, 1};
        int hi_tab [3] = '{3, 20, 1};
        int cycles;
        for (int i = 0; i < 3; i++) begin
            t_lo = TIME_W'(lo_tab[i]);
            t_hi = TIME_W'(hi_tab[i]);
            // Both phases carry the new lengths after the first strobe
            wait_strobe(cycles);
            wait_strobe(cycles);
            wait_strobe(cycles);
            compare_count(CNT_W'(cycles), CNT_W'(lo_tab[i] + hi_tab[i]), "strobe spacing");
        end
    endtask

    task automatic test_clean_link();
        link_status_t exp_st;
        start_link(8'd16, 8'd16, SEED32, PRBS32_EQN);
        wait_lock(LOCK_BITS + PRBS_WIDTH + 4);
        run_bits(200);
        // Bits are counted only from lock onward
        exp_st.locked    = 1'b1;
        exp_st.bit_count = CNT_W'(200);
        exp_st.err_count = '0;
        compare_status(status, exp_st, "status after 200 clean bits");
    endtask

    task automatic test_single_error();
        int taps;
        taps = $countones(eqn);
        inject_error();
        // Wrong bit itself plus once per tap as it moves through the history
        err_exp = err_exp + CNT_W'(taps + 1);
        run_bits(PRBS_WIDTH + 2);
        compare_count(status.err_count, err_exp, "errors after one flip");
    endtask

    task automatic test_random_errors();
        int taps;
        int gap;
        taps = $countones(eqn);
        for (int i = 0; i < 5; i++) begin
            random_bits(4, gap);
            run_bits(39 + gap);
            inject_error();
        end
        run_bits(PRBS_WIDTH + 2);
        err_exp = err_exp + CNT_W'(5 * (taps + 1));
        compare_count(status.err_count, err_exp, "errors after five flips");
    endtask

    task automatic test_other_polynomial();
        link_status_t exp_st;
        start_link(8'd16, 8'd16, SEED7, PRBS7_EQN);
        wait_lock(LOCK_BITS + PRBS_WIDTH + 4);
        run_bits(150);
        exp_st.locked    = 1'b1;
        exp_st.bit_count = CNT_W'(150);
        exp_st.err_count = '0;
        compare_status(status, exp_st, "PRBS7 status after 150 bits");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        emu_rst   = 1'b1;
        t_lo      = 8'd16;
        t_hi      = 8'd16;
        seed      = SEED32;
        eqn       = PRBS32_EQN;
        inj_err   = 1'b0;
        lfsr_q    = LFSR_SEED;
        err_exp   = '0;
        err_total = 0;
        run_done  = 1'b0;
        test_reset();
        test_strobe_period();
        test_clean_link();
        test_single_error();
        test_random_errors();
        test_other_polynomial();
        run_done = 1'b1;
        $display("Finished with no errors");
        $finish;
    end

    // Run stopped early by a failed assertion
    final begin
        if (!run_done && err_total == 0) begin
            $display("Finished with errors");
        end
    end

endmodule

// File: verilog.f
source/emu_link_pkg.sv
source/osc_model_core.sv
source/prbs_generator_syn.sv
source/tx_core.sv
source/chan_core.sv
source/rx_core.sv
source/emu_link_top.sv
dv/emu_link_chk.sv
dv/tb.sv

// File: run.sh
#!/bin/sh
# Build and run the link simulation with Verilator
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb -f verilog.f -o Vtb \
    || { echo "Build failed"; exit 1; }
./obj_dir/Vtb > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "Simulation ended early"; exit 1; }
echo "Simulation passed"
exit 0
